//--- logic/vid_pkg.sv
/* shared geometry, register numbers and types of the video controller.
   sync pulses are active high; the display is 16x8 pixels of 4 bits each */
package vid_pkg;

    localparam int H_VISIBLE    = 16;   // pixels per line shown
    localparam int H_TOTAL      = 24;
    localparam int H_SYNC_START = 18;
    localparam int H_SYNC_LEN   = 2;
    localparam int V_VISIBLE    = 8;    // lines per frame shown
    localparam int V_TOTAL      = 12;
    localparam int V_SYNC_START = 9;
    localparam int V_SYNC_LEN   = 1;
    localparam int VRAM_AW      = 8;    // 256 words
    localparam int PIX_LAT      = 4;    // counters to registered rgb

    typedef logic [15:0]        vram_word_t;    // four pixels, msn first
    typedef logic [VRAM_AW-1:0] vram_addr_t;
    typedef logic [3:0]         pal_idx_t;
    typedef logic [4:0]         hcount_t;
    typedef logic [3:0]         vcount_t;
    typedef logic [3:0]         intr_t;         // bit 0 vblank, bit 1 line match

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color_t;

    typedef enum logic [3:0] {
        REG_VRAM_ADDR = 4'h0,   // write starts a prefetch
        REG_VRAM_DATA = 4'h1,
        REG_VRAM_INCR = 4'h2,
        REG_PAL_ADDR  = 4'h3,
        REG_PAL_DATA  = 4'h4,   // write only
        REG_DISP_BASE = 4'h5,
        REG_INTR      = 4'h6,
        REG_LINE_CMP  = 4'h7
    } reg_num_e;

endpackage

//--- logic/vram_req_if.sv
/* cpu side vram request link. req and payload hold until grant,
   read data returns with a one cycle rvalid two cycles after grant */
interface vram_req_if;

    logic                req;      // held until grant
    logic                wr;       // 1 write, 0 read
    vid_pkg::vram_addr_t addr;
    vid_pkg::vram_word_t wdata;
    logic                grant;    // single cycle
    logic                rvalid;   // grant + 2
    vid_pkg::vram_word_t rdata;

    modport ctrl (output req, wr, addr, wdata, input grant, rvalid, rdata);
    modport arb  (input req, wr, addr, wdata, output grant, rvalid, rdata);

endinterface

//--- logic/bram_1r1w.sv
/* simple dual port ram, one write and one registered read port.
   read during write to the same address returns the old entry. no reset */
module bram_1r1w #(
    parameter type data_t = logic [15:0],
    parameter int  AW     = 8
) (
    input  logic          clk,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  data_t         wdata_i,
    input  logic          re_i,
    input  logic [AW-1:0] raddr_i,
    output data_t         rdata_o
);
    data_t mem [2**AW];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem[raddr_i];    // one cycle latency
        end
    end

endmodule

//--- logic/vram_arb.sv
/* single port vram arbiter. video reads always win and return data exactly
   two cycles later; a cpu access waits for the next cycle without a video read */
module vram_arb (
    input  logic                clk,
    input  logic                reset_i,
    vram_req_if.arb             cpu,
    input  logic                vid_rd_i,
    input  vid_pkg::vram_addr_t vid_addr_i,
    output vid_pkg::vram_word_t vid_data_o
);
    logic                cpu_go;        // cpu owns the port this cycle
    logic                cpu_rd;
    logic [1:0]          cpu_tag_q;     // cpu read in flight, per stage
    logic                vid_tag_q;     // ram output belongs to video
    vid_pkg::vram_word_t ram_q;

    assign cpu_go     = cpu.req && !vid_rd_i;
    assign cpu_rd     = cpu_go && !cpu.wr;
    assign cpu.grant  = cpu_go;
    assign cpu.rvalid = cpu_tag_q[1];

    bram_1r1w #(
        .data_t(vid_pkg::vram_word_t),
        .AW    (vid_pkg::VRAM_AW)
    ) i_vram (
        .clk    (clk),
        .we_i   (cpu_go && cpu.wr),
        .waddr_i(cpu.addr),
        .wdata_i(cpu.wdata),
        .re_i   (vid_rd_i || cpu_rd),
        .raddr_i(vid_rd_i ? vid_addr_i : cpu.addr),
        .rdata_o(ram_q)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cpu_tag_q <= '0;
            vid_tag_q <= 1'b0;
        end else begin
            cpu_tag_q <= {cpu_tag_q[0], cpu_rd};
            vid_tag_q <= vid_rd_i;
        end
    end

    // steer the registered word to its owner
    always_ff @(posedge clk) begin
        if (vid_tag_q) begin
            vid_data_o <= ram_q;
        end
        if (cpu_tag_q[0]) begin
            cpu.rdata <= ram_q;
        end
    end

    // video reads are spaced out, so a cpu access loses one cycle at most
    a_cpu_wait_bounded: assert property (@(posedge clk) disable iff (reset_i)
        cpu.req && vid_rd_i |=> cpu.grant);

endmodule

//--- logic/bus_regs.sv
/* cpu register file. odd byte write completes a word, reads answer one cycle
   after the strobe. allow about 4 cycles after a vram access before the next one.
   palette address advances after each palette data write */
module bus_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                bus_cs_n_i,
    input  logic                bus_rd_nwr_i,
    input  vid_pkg::reg_num_e   bus_reg_num_i,
    input  logic                bus_bytesel_i,
    input  logic [7:0]          bus_data_i,
    output logic [7:0]          bus_data_o,
    output logic                bus_intr_o,
    vram_req_if.ctrl            vram,
    output logic                pal_we_o,
    output vid_pkg::pal_idx_t   pal_waddr_o,
    output vid_pkg::color_t     pal_wdata_o,
    output vid_pkg::vram_addr_t disp_base_o,
    output vid_pkg::vcount_t    line_cmp_o,
    input  logic                vblank_start_i,
    input  logic                line_match_i
);
    logic [7:0]          hi_q;          // even byte waiting for odd half
    logic [15:0]         word;
    logic                wr_even;
    logic                wr_odd;
    logic                rd_any;
    logic                vaddr_wr;      // new address, prefetch
    logic                vdata_wr;
    logic                vdata_rd;      // odd byte read, next prefetch
    vid_pkg::vram_addr_t vram_addr_q;
    vid_pkg::vram_addr_t vram_incr_q;
    vid_pkg::vram_addr_t vram_next;
    vid_pkg::vram_word_t rd_word_q;     // last prefetched word
    vid_pkg::pal_idx_t   pal_addr_q;
    vid_pkg::intr_t      mask_q;
    vid_pkg::intr_t      status_q;
    vid_pkg::intr_t      intr_src;
    vid_pkg::intr_t      intr_clr;
    logic [15:0]         rd_sel;

    assign wr_even   = !bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i;
    assign wr_odd    = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;
    assign rd_any    = !bus_cs_n_i && bus_rd_nwr_i;
    assign word      = {hi_q, bus_data_i};
    assign vaddr_wr  = wr_odd && (bus_reg_num_i == vid_pkg::REG_VRAM_ADDR);
    assign vdata_wr  = wr_odd && (bus_reg_num_i == vid_pkg::REG_VRAM_DATA);
    assign vdata_rd  = rd_any && bus_bytesel_i && (bus_reg_num_i == vid_pkg::REG_VRAM_DATA);
    assign vram_next = vram_addr_q + vram_incr_q;

    // palette writes go straight through, the ram takes them this edge
    assign pal_we_o    = wr_odd && (bus_reg_num_i == vid_pkg::REG_PAL_DATA);
    assign pal_waddr_o = pal_addr_q;
    assign pal_wdata_o = vid_pkg::color_t'(word[11:0]);

    assign intr_src = {2'b00, line_match_i, vblank_start_i};
    assign intr_clr = (wr_odd && bus_reg_num_i == vid_pkg::REG_INTR) ? hi_q[3:0] : '0;

    always_comb begin
        case (bus_reg_num_i)
            vid_pkg::REG_VRAM_ADDR: rd_sel = 16'(vram_addr_q);
            vid_pkg::REG_VRAM_DATA: rd_sel = rd_word_q;
            vid_pkg::REG_VRAM_INCR: rd_sel = 16'(vram_incr_q);
            vid_pkg::REG_PAL_ADDR:  rd_sel = 16'(pal_addr_q);
            vid_pkg::REG_DISP_BASE: rd_sel = 16'(disp_base_o);
            vid_pkg::REG_INTR:      rd_sel = {4'h0, mask_q, 4'h0, status_q};  // mask high
            vid_pkg::REG_LINE_CMP:  rd_sel = 16'(line_cmp_o);
            default:                rd_sel = '0;    // palette is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram.req    <= 1'b0;
            vram_addr_q <= '0;
            vram_incr_q <= vid_pkg::vram_addr_t'(1);
            pal_addr_q  <= '0;
            disp_base_o <= '0;
            line_cmp_o  <= '0;
            mask_q      <= '0;
            status_q    <= '0;
            bus_intr_o  <= 1'b0;
        end else begin
            if (vram.grant) begin
                vram.req <= 1'b0;
                if (vram.wr) begin
                    vram_addr_q <= vram_next;   // write done, step on
                end
            end
            if (wr_odd) begin
                case (bus_reg_num_i)
                    vid_pkg::REG_VRAM_ADDR: vram_addr_q <= word[vid_pkg::VRAM_AW-1:0];
                    vid_pkg::REG_VRAM_INCR: vram_incr_q <= word[vid_pkg::VRAM_AW-1:0];
                    vid_pkg::REG_PAL_ADDR:  pal_addr_q  <= word[3:0];
                    vid_pkg::REG_PAL_DATA:  pal_addr_q  <= pal_addr_q + 1'b1;
                    vid_pkg::REG_DISP_BASE: disp_base_o <= word[vid_pkg::VRAM_AW-1:0];
                    vid_pkg::REG_INTR:      mask_q      <= {2'b00, bus_data_i[1:0]};
                    vid_pkg::REG_LINE_CMP:  line_cmp_o  <= bus_data_i[3:0];
                    default: ;
                endcase
            end
            if (vdata_rd) begin
                vram_addr_q <= vram_next;
            end
            if (vaddr_wr || vdata_wr || vdata_rd) begin
                vram.req <= 1'b1;
            end
            // status latches even when masked off
            status_q   <= (status_q | intr_src) & ~intr_clr;
            bus_intr_o <= |(intr_src & mask_q & ~status_q);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_even) begin
            hi_q <= bus_data_i;
        end
        if (vaddr_wr) begin
            vram.wr   <= 1'b0;
            vram.addr <= word[vid_pkg::VRAM_AW-1:0];
        end
        if (vdata_wr) begin
            vram.wr    <= 1'b1;
            vram.addr  <= vram_addr_q;
            vram.wdata <= word;
        end
        if (vdata_rd) begin
            vram.wr   <= 1'b0;
            vram.addr <= vram_next;     // prefetch the next word
        end
        if (vram.rvalid) begin
            rd_word_q <= vram.rdata;
        end
        if (rd_any) begin
            bus_data_o <= bus_bytesel_i ? rd_sel[7:0] : rd_sel[15:8];
        end
    end

    // a pending access must wait for its grant with its payload unchanged
    a_req_held: assert property (@(posedge clk) disable iff (reset_i)
        vram.req && !vram.grant |=> vram.req && $stable(vram.addr) && $stable(vram.wr)
            && (!vram.wr || $stable(vram.wdata)));

    // sources are single cycle strobes, so the interrupt is a single pulse
    a_intr_pulse: assert property (@(posedge clk) disable iff (reset_i)
        bus_intr_o |=> !bus_intr_o);

endmodule

//--- logic/video_timing.sv
/* scan counters with syncs, display enable and interrupt strobes.
   all outputs are registered from the next count so they line up with h_o, v_o */
module video_timing (
    input  logic             clk,
    input  logic             reset_i,
    input  vid_pkg::vcount_t line_cmp_i,
    output vid_pkg::hcount_t h_o,
    output vid_pkg::vcount_t v_o,
    output logic             hsync_o,
    output logic             vsync_o,
    output logic             de_o,
    output logic             vblank_start_o,
    output logic             line_match_o
);
    vid_pkg::hcount_t h_nxt;
    vid_pkg::vcount_t v_nxt;
    logic             h_wrap;   // last pixel of the line

    assign h_wrap = (h_o == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1));

    always_comb begin
        h_nxt = h_wrap ? '0 : h_o + 1'b1;
        v_nxt = v_o;
        if (h_wrap) begin
            v_nxt = (v_o == vid_pkg::vcount_t'(vid_pkg::V_TOTAL - 1)) ? '0 : v_o + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_o            <= '0;
            v_o            <= '0;
            hsync_o        <= 1'b0;
            vsync_o        <= 1'b0;
            de_o           <= 1'b1;     // 0,0 is the first visible pixel
            vblank_start_o <= 1'b0;
            line_match_o   <= 1'b0;
        end else begin
            h_o     <= h_nxt;
            v_o     <= v_nxt;
            hsync_o <= (h_nxt >= vid_pkg::H_SYNC_START) &&
                       (h_nxt <  vid_pkg::H_SYNC_START + vid_pkg::H_SYNC_LEN);
            vsync_o <= (v_nxt >= vid_pkg::V_SYNC_START) &&
                       (v_nxt <  vid_pkg::V_SYNC_START + vid_pkg::V_SYNC_LEN);
            de_o    <= (h_nxt < vid_pkg::H_VISIBLE) && (v_nxt < vid_pkg::V_VISIBLE);
            // strobes fire on the first pixel of their line
            vblank_start_o <= (h_nxt == '0) && (v_nxt == vid_pkg::V_VISIBLE);
            line_match_o   <= (h_nxt == '0) && (v_nxt == line_cmp_i);
        end
    end

endmodule

//--- logic/pixel_fetch.sv
/* one vram read per 4 visible pixels, nibbles go out msn first as palette
   index. rgb and syncs lag the counters by PIX_LAT, rgb is zero in blanking */
module pixel_fetch (
    input  logic                clk,
    input  logic                reset_i,
    input  vid_pkg::hcount_t    h_i,
    input  vid_pkg::vcount_t    v_i,
    input  logic                hsync_i,
    input  logic                vsync_i,
    input  logic                de_i,
    input  vid_pkg::vram_addr_t disp_base_i,
    output logic                vid_rd_o,
    output vid_pkg::vram_addr_t vid_addr_o,
    input  vid_pkg::vram_word_t vid_data_i,
    output vid_pkg::pal_idx_t   pal_raddr_o,
    input  vid_pkg::color_t     pal_rdata_i,
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);
    logic [1:0]                  rd_d;      // fetch in flight, word lands at [1]
    vid_pkg::vram_word_t         shift_q;   // remaining nibbles
    logic [vid_pkg::PIX_LAT-1:0] hs_d;
    logic [vid_pkg::PIX_LAT-1:0] vs_d;
    logic [vid_pkg::PIX_LAT-1:0] de_d;

    // word at base + v*4 + h/4, wraps in the address width
    assign vid_rd_o   = de_i && (h_i[1:0] == 2'b00);
    assign vid_addr_o = disp_base_i + vid_pkg::vram_addr_t'({v_i, 2'b00})
                      + vid_pkg::vram_addr_t'(h_i[4:2]);

    // first nibble straight from the arbiter, rest from the shifter
    assign pal_raddr_o = rd_d[1] ? vid_data_i[15:12] : shift_q[15:12];

    assign hsync_o = hs_d[vid_pkg::PIX_LAT-1];
    assign vsync_o = vs_d[vid_pkg::PIX_LAT-1];
    assign dv_de_o = de_d[vid_pkg::PIX_LAT-1];

    always_ff @(posedge clk) begin
        shift_q <= rd_d[1] ? {vid_data_i[11:0], 4'h0} : {shift_q[11:0], 4'h0};
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_d    <= '0;
            hs_d    <= '0;
            vs_d    <= '0;
            de_d    <= '0;
            red_o   <= '0;
            green_o <= '0;
            blue_o  <= '0;
        end else begin
            rd_d <= {rd_d[0], vid_rd_o};
            hs_d <= {hs_d[vid_pkg::PIX_LAT-2:0], hsync_i};
            vs_d <= {vs_d[vid_pkg::PIX_LAT-2:0], vsync_i};
            de_d <= {de_d[vid_pkg::PIX_LAT-2:0], de_i};
            // palette data is one stage short of the output, so use de one back
            if (de_d[vid_pkg::PIX_LAT-2]) begin
                red_o   <= pal_rdata_i.r;
                green_o <= pal_rdata_i.g;
                blue_o  <= pal_rdata_i.b;
            end else begin
                red_o   <= '0;
                green_o <= '0;
                blue_o  <= '0;
            end
        end
    end

endmodule

//--- logic/vid_top.sv
/* bitmap video controller top, 8-bit register bus plus 4:4:4 rgb and syncs.
   one bus access per cycle with bus_cs_n_i low, no wait states */
module vid_top (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       bus_cs_n_i,      // strobe, active low
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,   // 0 even/high byte, 1 odd/low byte
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,
    output logic       bus_intr_o,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       dv_de_o
);
    vid_pkg::hcount_t    h;
    vid_pkg::vcount_t    v;
    logic                hsync_t;       // aligned with the counters
    logic                vsync_t;
    logic                de_t;
    logic                vblank_start;
    logic                line_match;
    vid_pkg::vcount_t    line_cmp;
    vid_pkg::vram_addr_t disp_base;
    logic                vid_rd;
    vid_pkg::vram_addr_t vid_addr;
    vid_pkg::vram_word_t vid_data;
    logic                pal_we;
    vid_pkg::pal_idx_t   pal_waddr;
    vid_pkg::color_t     pal_wdata;
    vid_pkg::pal_idx_t   pal_raddr;
    vid_pkg::color_t     pal_rdata;

    vram_req_if vram_bus ();

    bus_regs i_bus_regs (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(vid_pkg::reg_num_e'(bus_reg_num_i)),
        .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i),
        .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
        .vram(vram_bus.ctrl),
        .pal_we_o(pal_we), .pal_waddr_o(pal_waddr), .pal_wdata_o(pal_wdata),
        .disp_base_o(disp_base), .line_cmp_o(line_cmp),
        .vblank_start_i(vblank_start), .line_match_i(line_match)
    );

    vram_arb i_vram_arb (
        .clk(clk), .reset_i(reset_i), .cpu(vram_bus.arb),
        .vid_rd_i(vid_rd), .vid_addr_i(vid_addr), .vid_data_o(vid_data)
    );

    video_timing i_video_timing (
        .clk(clk), .reset_i(reset_i), .line_cmp_i(line_cmp),
        .h_o(h), .v_o(v), .hsync_o(hsync_t), .vsync_o(vsync_t), .de_o(de_t),
        .vblank_start_o(vblank_start), .line_match_o(line_match)
    );

    pixel_fetch i_pixel_fetch (
        .clk(clk), .reset_i(reset_i), .h_i(h), .v_i(v),
        .hsync_i(hsync_t), .vsync_i(vsync_t), .de_i(de_t), .disp_base_i(disp_base),
        .vid_rd_o(vid_rd), .vid_addr_o(vid_addr), .vid_data_i(vid_data),
        .pal_raddr_o(pal_raddr), .pal_rdata_i(pal_rdata),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    // 16 entry palette, read every cycle
    bram_1r1w #(
        .data_t(vid_pkg::color_t),
        .AW    ($bits(vid_pkg::pal_idx_t))
    ) i_palette (
        .clk(clk), .we_i(pal_we), .waddr_i(pal_waddr), .wdata_i(pal_wdata),
        .re_i(1'b1), .raddr_i(pal_raddr), .rdata_o(pal_rdata)
    );

endmodule

//--- dv/vid_tb.sv
/* testbench for the bitmap video controller. shadow vram, palette and base
   give the expected image; outputs are sampled on the falling clock edge */
module vid_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS     = 20;
    localparam int FRAME_NS   = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL * CLK_NS;
    localparam int TESTS      = 5;
    localparam int BUS_OPS    = 256;    // word accesses of all tests, rounded up
    localparam int TIMEOUT_NS = TESTS * 6 * FRAME_NS + BUS_OPS * 12 * CLK_NS;
    localparam int FILL_WORDS = 40;     // burst runs past the 32 shown words

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    logic [7:0] bus_data_i;
    logic [7:0] bus_data_o;
    logic       bus_intr_o;
    logic [3:0] red_o;
    logic [3:0] green_o;
    logic [3:0] blue_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;

    vid_pkg::vram_word_t shadow_vram [2**vid_pkg::VRAM_AW];
    vid_pkg::color_t     shadow_pal [16];
    vid_pkg::vram_addr_t shadow_base;
    vid_pkg::vram_addr_t model_addr;    // address register as the dut should hold it
    vid_pkg::vram_addr_t model_incr;
    vid_pkg::pal_idx_t   model_pal;

    string cur_test;
    int    errors;
    int    checks;
    int    tests_run;
    int    err_at_start;
    int    intr_count;                  // bus_intr_o high samples
    int    pix_checked;
    bit    pix_check;                   // image compare on
    int    x_pos;
    int    y_pos;
    int    hs_cnt;                      // hsync pulses since last vsync
    bit    frame_seen;
    bit    de_q;
    bit    hs_q;
    bit    vs_q;

    vid_top i_vid_top (
        .clk(clk), .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_intr_o(bus_intr_o),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // word at base + y*4 + x/4, msn is the leftmost pixel
    function automatic vid_pkg::color_t expected_pixel(input int x, input int y);
        vid_pkg::vram_addr_t a;
        vid_pkg::vram_word_t w;
        vid_pkg::pal_idx_t   n;
        a = shadow_base + vid_pkg::vram_addr_t'(y * 4 + x / 4);
        w = shadow_vram[a];
        n = w[15 - 4 * (x % 4) -: 4];
        return shadow_pal[n];
    endfunction

    task automatic check_word(input string what, input vid_pkg::vram_word_t exp,
                              input vid_pkg::vram_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_color(input string what, input vid_pkg::color_t exp,
                               input vid_pkg::color_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_intr(input string what, input vid_pkg::intr_t exp,
                              input vid_pkg::intr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("Mismatch in %s, %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    // one strobe cycle; read data shows up after the sampling edge
    task automatic bus_access(input logic rd, input vid_pkg::reg_num_e num, input logic bsel,
                              input logic [7:0] wdata, output logic [7:0] rdata);
        @(posedge clk);
        bus_cs_n_i    <= 1'b0;
        bus_rd_nwr_i  <= rd;
        bus_reg_num_i <= num;
        bus_bytesel_i <= bsel;
        bus_data_i    <= wdata;
        @(posedge clk);
        bus_cs_n_i    <= 1'b1;
        @(negedge clk);
        rdata = bus_data_o;
    endtask

    task automatic write_reg(input vid_pkg::reg_num_e num, input logic [15:0] data);
        logic [7:0] unused;
        bus_access(1'b0, num, 1'b0, data[15:8], unused);   // even byte latched
        bus_access(1'b0, num, 1'b1, data[7:0], unused);    // word completes
        if (num == vid_pkg::REG_VRAM_ADDR) begin
            repeat (4) @(posedge clk);  // let the prefetch land
        end
    endtask

    task automatic read_reg(input vid_pkg::reg_num_e num, output logic [15:0] data);
        bus_access(1'b1, num, 1'b0, 8'h00, data[15:8]);
        bus_access(1'b1, num, 1'b1, 8'h00, data[7:0]);
        if (num == vid_pkg::REG_VRAM_DATA) begin
            repeat (4) @(posedge clk);  // next prefetch
        end
    endtask

    task automatic set_vram_addr(input vid_pkg::vram_addr_t a);
        write_reg(vid_pkg::REG_VRAM_ADDR, 16'(a));
        model_addr = a;
    endtask

    task automatic set_vram_incr(input vid_pkg::vram_addr_t i);
        write_reg(vid_pkg::REG_VRAM_INCR, 16'(i));
        model_incr = i;
    endtask

    task automatic write_vram(input vid_pkg::vram_word_t w);
        write_reg(vid_pkg::REG_VRAM_DATA, w);
        shadow_vram[model_addr] = w;
        model_addr = model_addr + model_incr;
    endtask

    task automatic read_vram_check();
        logic [15:0] got;
        read_reg(vid_pkg::REG_VRAM_DATA, got);
        check_word($sformatf("word at %h", model_addr), shadow_vram[model_addr], got);
        model_addr = model_addr + model_incr;
    endtask

    task automatic write_pal(input vid_pkg::color_t c);
        write_reg(vid_pkg::REG_PAL_DATA, {4'h0, c});
        shadow_pal[model_pal] = c;
        model_pal = model_pal + 1'b1;
    endtask

    task automatic read_intr_check(input vid_pkg::intr_t status, input vid_pkg::intr_t mask);
        logic [15:0] got;
        read_reg(vid_pkg::REG_INTR, got);
        check_intr("status", status, got[3:0]);
        check_intr("mask", mask, got[11:8]);    // mask sits in the high byte
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(posedge vsync_o);
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        err_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_at_start) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, errors - err_at_start);
        end
    endtask

    task automatic run_vram_readback();
        vid_pkg::vram_addr_t a0;
        vid_pkg::vram_addr_t a1;
        logic [31:0]         rnd;
        start_test("vram_readback");
        rnd = $urandom;
        a0  = rnd[vid_pkg::VRAM_AW-1:0];
        rnd = $urandom;
        a1  = rnd[vid_pkg::VRAM_AW-1:0];
        set_vram_incr(1);
        set_vram_addr(a0);
        repeat (8) begin
            rnd = $urandom;
            write_vram(rnd[15:0]);
        end
        set_vram_incr(3);               // stride run, may overlap the first one
        set_vram_addr(a1);
        repeat (8) begin
            rnd = $urandom;
            write_vram(rnd[15:0]);
        end
        set_vram_incr(1);
        set_vram_addr(a0);
        repeat (8) read_vram_check();
        set_vram_incr(3);
        set_vram_addr(a1);
        repeat (8) read_vram_check();
        end_test();
    endtask

    task automatic run_frame_image();
        logic [31:0] rnd;
        int          n0;
        start_test("frame_image");
        write_reg(vid_pkg::REG_PAL_ADDR, 16'h0000);
        model_pal = '0;
        repeat (16) begin
            rnd = $urandom;
            write_pal(rnd[11:0]);
        end
        rnd = $urandom;
        shadow_base = rnd[vid_pkg::VRAM_AW-1:0];
        write_reg(vid_pkg::REG_DISP_BASE, 16'(shadow_base));
        set_vram_incr(1);
        set_vram_addr(shadow_base);
        repeat (vid_pkg::H_VISIBLE / 4 * vid_pkg::V_VISIBLE) begin
            rnd = $urandom;
            write_vram(rnd[15:0]);
        end
        wait_frames(1);
        pix_check = 1'b1;
        n0 = pix_checked;
        wait_frames(2);
        check_count("pixels checked", 2 * vid_pkg::H_VISIBLE * vid_pkg::V_VISIBLE,
                    pix_checked - n0);
        end_test();
    endtask

    // frame period here, the monitor does the line and blanking checks
    task automatic run_geometry();
        longint t0;
        start_test("blanking_geometry");
        wait_frames(1);
        t0 = $time;
        wait_frames(3);
        check_count("clocks per 3 frames", 3 * vid_pkg::H_TOTAL * vid_pkg::V_TOTAL,
                    int'(($time - t0) / CLK_NS));
        end_test();
    endtask

    task automatic run_interrupts();
        logic [31:0] rnd;
        start_test("interrupts");
        write_reg(vid_pkg::REG_INTR, 16'h0301);     // clear both, vblank on
        wait_frames(1);
        write_reg(vid_pkg::REG_INTR, 16'h0101);
        intr_count = 0;
        repeat (3) begin
            wait_frames(1);
            write_reg(vid_pkg::REG_INTR, 16'h0101); // acknowledge each frame
        end
        check_count("vblank pulses with clear", 3, intr_count);
        intr_count = 0;
        wait_frames(3);
        check_count("vblank pulses without clear", 1, intr_count);
        read_intr_check(4'h3, 4'h1);    // line compare 0 hits every frame too
        write_reg(vid_pkg::REG_INTR, 16'h0300);     // all masked off
        intr_count = 0;
        wait_frames(2);
        check_count("pulses while masked off", 0, intr_count);
        read_intr_check(4'h3, 4'h0);
        rnd = $urandom % vid_pkg::V_TOTAL;
        write_reg(vid_pkg::REG_LINE_CMP, {12'h000, rnd[3:0]});
        write_reg(vid_pkg::REG_INTR, 16'h0302);     // only line match on
        wait_frames(1);
        write_reg(vid_pkg::REG_INTR, 16'h0202);
        intr_count = 0;
        repeat (2) begin
            wait_frames(1);
            write_reg(vid_pkg::REG_INTR, 16'h0202);
        end
        check_count($sformatf("line %0d match pulses", rnd[3:0]), 2, intr_count);
        write_reg(vid_pkg::REG_INTR, 16'h0300);
        end_test();
    endtask

    task automatic run_contention();
        logic [31:0] rnd;
        int          n0;
        start_test("contention");
        pix_check = 1'b0;               // image changes under the burst
        set_vram_incr(1);
        wait_frames(1);
        @(posedge dv_de_o);
        set_vram_addr(shadow_base);
        repeat (FILL_WORDS) begin
            rnd = $urandom;
            write_vram(rnd[15:0]);
        end
        set_vram_addr(shadow_base);
        repeat (FILL_WORDS) read_vram_check();
        wait_frames(1);
        pix_check = 1'b1;
        n0 = pix_checked;
        wait_frames(2);
        check_count("pixels checked", 2 * vid_pkg::H_VISIBLE * vid_pkg::V_VISIBLE,
                    pix_checked - n0);
        end_test();
    endtask

    // scan monitor, falls between the output edges
    always @(negedge clk) begin
        if (!reset_i) begin
            if (vsync_o && !vs_q) begin
                if (frame_seen) begin
                    check_count("visible lines per frame", vid_pkg::V_VISIBLE, y_pos);
                    check_count("hsync pulses per frame", vid_pkg::V_TOTAL, hs_cnt);
                end
                frame_seen = 1'b1;
                y_pos  = 0;
                hs_cnt = 0;
            end
            if (hsync_o && !hs_q) begin
                hs_cnt++;
            end
            if (bus_intr_o) begin
                intr_count++;
            end
            if (dv_de_o) begin
                if (pix_check) begin
                    check_color($sformatf("pixel %0d,%0d", x_pos, y_pos),
                                expected_pixel(x_pos, y_pos), {red_o, green_o, blue_o});
                    pix_checked++;
                end
                x_pos++;
            end else begin
                if (de_q && frame_seen) begin
                    check_count("pixels per line", vid_pkg::H_VISIBLE, x_pos);
                end
                if (de_q) begin
                    y_pos++;            // line just ended
                end
                x_pos = 0;
                if ({red_o, green_o, blue_o} !== 12'h000) begin
                    errors++;
                    $display("%s: rgb output is not zero while display enable is low",
                             cur_test);
                end
            end
            de_q = dv_de_o;
            hs_q = hsync_o;
            vs_q = vsync_o;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: the tests did not finish in the allowed time");
        $display("Errors found");
        $finish;
    end

    initial begin
        void'($urandom(32'h576a8f15));
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        model_addr    = '0;
        model_incr    = vid_pkg::vram_addr_t'(1);   // reset value of VRAM_INCR
        model_pal     = '0;
        shadow_base   = '0;
        cur_test      = "reset";
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        run_vram_readback();
        run_frame_image();
        run_geometry();
        run_interrupts();
        run_contention();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/vid_pkg.sv
logic/vram_req_if.sv
logic/bram_1r1w.sv
logic/vram_arb.sv
logic/bus_regs.sv
logic/video_timing.sv
logic/pixel_fetch.sv
logic/vid_top.sv
dv/vid_tb.sv

//--- Bender.yml
package:
  name: vid_ctrl

sources:
  - files:
      - logic/vid_pkg.sv
      - logic/vram_req_if.sv
      - logic/bram_1r1w.sv
      - logic/vram_arb.sv
      - logic/bus_regs.sv
      - logic/video_timing.sv
      - logic/pixel_fetch.sv
      - logic/vid_top.sv
  - target: simulation
    files:
      - dv/vid_tb.sv
